/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+include
hw/rv_core_pkg.sv
hw/rv_decoder.sv
hw/rv_execute.sv
hw/rv_load_store.sv
hw/rv_regfile.sv
hw/rv_sequencer.sv
hw/rv_core.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv

/* hw/rv_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I multicycle core top, memories attach through request/valid ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_consts.svh"

module rv_core (
    input  wire logic                  clk,
    input  wire logic                  reset,
    output logic                       imem_req,
    output logic      [`RV_XLEN-1:0]   imem_addr,
    input  wire logic                  imem_valid,
    input  wire logic [`RV_XLEN-1:0]   imem_data,
    output logic                       dmem_req,
    output rv_core_pkg::dmem_req_t     dmem_cmd,
    input  wire logic                  dmem_valid,
    input  wire logic [`RV_XLEN-1:0]   dmem_rdata,
    output logic                       retire_valid,
    output rv_core_pkg::retire_t       retire
);

    rv_core_pkg::decoded_t dec;
    logic [`RV_XLEN-1:0]   inst;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   next_pc;
    logic [`RV_XLEN-1:0]   rd_wdata;
    logic [`RV_XLEN-1:0]   alu_result;
    logic [`RV_XLEN-1:0]   load_val;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;
    logic                  rf_we;

    rv_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .imem_valid   (imem_valid),
        .imem_data    (imem_data),
        .dmem_valid   (dmem_valid),
        .dec          (dec),
        .next_pc      (next_pc),
        .rd_wdata     (rd_wdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .inst         (inst),
        .pc           (pc),
        .dmem_req     (dmem_req),
        .rf_we        (rf_we),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    rv_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    // write port takes the retire record directly
    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (retire.rd),
        .wdata  (retire.wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    rv_execute u_execute (
        .dec        (dec),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .pc         (pc),
        .load_val   (load_val),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .rd_wdata   (rd_wdata)
    );

    rv_load_store u_load_store (
        .dec      (dec),
        .addr     (alu_result),   // rs1 + imm
        .rs2_val  (rs2_val),
        .rdata    (dmem_rdata),
        .cmd      (dmem_cmd),
        .load_val (load_val)
    );

endmodule

`default_nettype wire

/* hw/rv_core_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the core: ALU ops, formats, decode, memory and retire records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_N
    } inst_fmt_t;

    typedef struct packed {
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_XLEN-1:0]   imm;     // already sign extended
        inst_fmt_t             fmt;
        alu_op_t               alu_op;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  is_lui;
        logic                  writes_rd;
    } decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;    // word aligned
        logic [`RV_XLEN-1:0] wdata;   // replicated across lanes
        logic [3:0]          wmask;
        logic                we;
    } dmem_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   wdata;
        logic                  we;
    } retire_t;

endpackage

`default_nettype wire

/* hw/rv_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decode, purely combinational, fed from the instruction register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_consts.svh"

module rv_decoder (
    input  wire logic [`RV_XLEN-1:0] inst,
    output rv_core_pkg::decoded_t    dec
);

    logic [6:0] opcode;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct7 = inst[31:25];

    always_comb begin
        dec = '0;
        dec.opcode = opcode;
        dec.funct3 = inst[14:12];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (opcode)
            `RV_OP_OP:                                       dec.fmt = rv_core_pkg::FMT_R;
            `RV_OP_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR:         dec.fmt = rv_core_pkg::FMT_I;
            `RV_OP_STORE:                                    dec.fmt = rv_core_pkg::FMT_S;
            `RV_OP_BRANCH:                                   dec.fmt = rv_core_pkg::FMT_B;
            `RV_OP_LUI, `RV_OP_AUIPC:                        dec.fmt = rv_core_pkg::FMT_U;
            `RV_OP_JAL:                                      dec.fmt = rv_core_pkg::FMT_J;
            default:                                         dec.fmt = rv_core_pkg::FMT_N;
        endcase

        case (dec.fmt)
            rv_core_pkg::FMT_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            rv_core_pkg::FMT_S: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_core_pkg::FMT_B: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25],
                                           inst[11:8], 1'b0};
            rv_core_pkg::FMT_U: dec.imm = {inst[31:12], 12'h000};
            rv_core_pkg::FMT_J: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20],
                                           inst[30:21], 1'b0};
            default:            dec.imm = '0;
        endcase

        dec.is_load   = (opcode == `RV_OP_LOAD);
        dec.is_store  = (opcode == `RV_OP_STORE);
        dec.is_branch = (opcode == `RV_OP_BRANCH);
        dec.is_jal    = (opcode == `RV_OP_JAL);
        dec.is_jalr   = (opcode == `RV_OP_JALR);
        dec.is_lui    = (opcode == `RV_OP_LUI);
        // stores, branches and unknown opcodes leave rd alone
        dec.writes_rd = (dec.fmt == rv_core_pkg::FMT_R) || (dec.fmt == rv_core_pkg::FMT_I) ||
                        (dec.fmt == rv_core_pkg::FMT_U) || (dec.fmt == rv_core_pkg::FMT_J);

        // everything outside OP and OP_IMM just adds
        dec.alu_op = rv_core_pkg::ALU_ADD;
        if (opcode == `RV_OP_OP || opcode == `RV_OP_OP_IMM) begin
            case (dec.funct3)
                3'b000: if (opcode == `RV_OP_OP && funct7[5]) dec.alu_op = rv_core_pkg::ALU_SUB;
                3'b001: dec.alu_op = rv_core_pkg::ALU_SLL;
                3'b010: dec.alu_op = rv_core_pkg::ALU_SLT;
                3'b011: dec.alu_op = rv_core_pkg::ALU_SLTU;
                3'b100: dec.alu_op = rv_core_pkg::ALU_XOR;
                3'b101: dec.alu_op = funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                3'b110: dec.alu_op = rv_core_pkg::ALU_OR;
                default: dec.alu_op = rv_core_pkg::ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU, branch compare, next pc and write-back select for one instruction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_consts.svh"

module rv_execute (
    input  rv_core_pkg::decoded_t     dec,
    input  wire logic [`RV_XLEN-1:0]  rs1_val,
    input  wire logic [`RV_XLEN-1:0]  rs2_val,
    input  wire logic [`RV_XLEN-1:0]  pc,
    input  wire logic [`RV_XLEN-1:0]  load_val,
    output logic      [`RV_XLEN-1:0]  alu_result,
    output logic      [`RV_XLEN-1:0]  next_pc,
    output logic      [`RV_XLEN-1:0]  rd_wdata
);

    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;   // branch and JAL destination
    logic [4:0]          shamt;
    logic                taken;

    // LUI adds to zero, AUIPC to pc, all else to rs1
    assign alu_a = (dec.fmt == rv_core_pkg::FMT_U) ? (dec.is_lui ? '0 : pc) : rs1_val;
    assign alu_b = (dec.fmt == rv_core_pkg::FMT_R) ? rs2_val : dec.imm;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_core_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            rv_core_pkg::ALU_SLL:  alu_result = alu_a << shamt;
            rv_core_pkg::ALU_SLT:  alu_result = {31'd0, $signed(alu_a) < $signed(alu_b)};
            rv_core_pkg::ALU_SLTU: alu_result = {31'd0, alu_a < alu_b};
            rv_core_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            rv_core_pkg::ALU_SRL:  alu_result = alu_a >> shamt;
            rv_core_pkg::ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
            rv_core_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            rv_core_pkg::ALU_AND:  alu_result = alu_a & alu_b;
            default:               alu_result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            `RV_F3_BEQ:  taken = (rs1_val == rs2_val);
            `RV_F3_BNE:  taken = (rs1_val != rs2_val);
            `RV_F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            `RV_F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            `RV_F3_BLTU: taken = (rs1_val < rs2_val);
            `RV_F3_BGEU: taken = (rs1_val >= rs2_val);
            default:     taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + dec.imm;

    always_comb begin
        if (dec.is_jalr)
            next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
        else if (dec.is_jal || (dec.is_branch && taken))
            next_pc = pc_target;
        else
            next_pc = pc_plus4;
    end

    always_comb begin
        if (dec.is_jal || dec.is_jalr)
            rd_wdata = pc_plus4;      // link address
        else if (dec.is_load)
            rd_wdata = load_val;
        else
            rd_wdata = alu_result;
    end

endmodule

`default_nettype wire

/* hw/rv_load_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory request formatting and load data alignment and extension
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_consts.svh"

module rv_load_store (
    input  rv_core_pkg::decoded_t     dec,
    input  wire logic [`RV_XLEN-1:0]  addr,
    input  wire logic [`RV_XLEN-1:0]  rs2_val,
    input  wire logic [`RV_XLEN-1:0]  rdata,
    output rv_core_pkg::dmem_req_t    cmd,
    output logic      [`RV_XLEN-1:0]  load_val
);

    logic [3:0]          size_mask;   // before lane shift
    logic [`RV_XLEN-1:0] lane_data;   // addressed byte moved to lane 0

    always_comb begin
        case (dec.funct3)
            `RV_F3_B: size_mask = 4'b0001;
            `RV_F3_H: size_mask = 4'b0011;
            default:  size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        cmd.addr  = {addr[`RV_XLEN-1:2], 2'b00};
        cmd.we    = dec.is_store;
        cmd.wmask = dec.is_store ? (size_mask << addr[1:0]) : 4'b0000;
        case (dec.funct3)
            `RV_F3_B: cmd.wdata = {4{rs2_val[7:0]}};
            `RV_F3_H: cmd.wdata = {2{rs2_val[15:0]}};
            default:  cmd.wdata = rs2_val;
        endcase
    end

    assign lane_data = rdata >> {addr[1:0], 3'b000};

    always_comb begin
        case (dec.funct3)
            `RV_F3_B:  load_val = {{24{lane_data[7]}}, lane_data[7:0]};
            `RV_F3_H:  load_val = {{16{lane_data[15]}}, lane_data[15:0]};
            `RV_F3_W:  load_val = lane_data;
            `RV_F3_BU: load_val = {24'd0, lane_data[7:0]};
            `RV_F3_HU: load_val = {16'd0, lane_data[15:0]};
            default:   load_val = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer register file, two async reads and one write, x0 hardwired to zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_consts.svh"

module rv_regfile (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   we,
    input  wire logic [`RV_REG_AW-1:0]  waddr,
    input  wire logic [`RV_XLEN-1:0]    wdata,
    input  wire logic [`RV_REG_AW-1:0]  raddr1,
    input  wire logic [`RV_REG_AW-1:0]  raddr2,
    output logic      [`RV_XLEN-1:0]    rdata1,
    output logic      [`RV_XLEN-1:0]    rdata2
);

    logic [`RV_XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hw/rv_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pc, instruction register and the fetch / execute / memory control FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_consts.svh"

module rv_sequencer (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  imem_valid,
    input  wire logic [`RV_XLEN-1:0]   imem_data,
    input  wire logic                  dmem_valid,
    input  rv_core_pkg::decoded_t      dec,
    input  wire logic [`RV_XLEN-1:0]   next_pc,
    input  wire logic [`RV_XLEN-1:0]   rd_wdata,
    output logic                       imem_req,
    output logic      [`RV_XLEN-1:0]   imem_addr,
    output logic      [`RV_XLEN-1:0]   inst,
    output logic      [`RV_XLEN-1:0]   pc,
    output logic                       dmem_req,
    output logic                       rf_we,
    output logic                       retire_valid,
    output rv_core_pkg::retire_t       retire
);

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,    // also waits here for the data memory
        MEMORY      // data returned, retire the load or store
    } state_t;

    state_t              state;
    state_t              next_state;
    logic                mem_op;
    logic [`RV_XLEN-1:0] wb_q;       // write-back value held across the memory wait

    assign mem_op = dec.is_load || dec.is_store;

    always_comb begin
        case (state)
            FETCH:   next_state = (imem_req && imem_valid) ? EXECUTE : FETCH;
            EXECUTE: begin
                if (!mem_op)
                    next_state = FETCH;
                else
                    next_state = dmem_valid ? MEMORY : EXECUTE;
            end
            default: next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= FETCH;
            imem_req <= 1'b0;
            pc       <= `RV_RESET_PC;
        end else begin
            state    <= next_state;
            imem_req <= (next_state == FETCH);   // drops on the cycle after imem_valid
            if (retire_valid)
                pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && imem_req && imem_valid)
            inst <= imem_data;
        if (state == EXECUTE && dmem_valid)
            wb_q <= rd_wdata;                    // load data only valid with the pulse
    end

    assign imem_addr    = pc;
    assign dmem_req     = (state == EXECUTE) && mem_op;
    assign retire_valid = ((state == EXECUTE) && !mem_op) || (state == MEMORY);
    assign rf_we        = retire_valid && dec.writes_rd && (dec.rd != '0);

    always_comb begin
        retire.pc    = pc;
        retire.rd    = dec.rd;
        retire.wdata = (state == MEMORY) ? wb_q : rd_wdata;
        retire.we    = rf_we;
    end

endmodule

`default_nettype wire

/* include/rv_core_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, reset address and RV32I encodings for the multicycle core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

`define RV_XLEN     32
`define RV_REG_AW   5
`define RV_RESET_PC 32'h8000_0000

// major opcodes
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_OP     7'b0110011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111

// branch compares
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// load and store sizes
`define RV_F3_B  3'b000
`define RV_F3_H  3'b001
`define RV_F3_W  3'b010
`define RV_F3_BU 3'b100
`define RV_F3_HU 3'b101

`endif

/* verification/rv_core_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions on the memory and retire ports of the core, attached with bind
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_consts.svh"

module rv_core_properties (
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                imem_req,
    input wire logic [`RV_XLEN-1:0] imem_addr,
    input wire logic                imem_valid,
    input wire logic                dmem_req,
    input rv_core_pkg::dmem_req_t   dmem_cmd,
    input wire logic                dmem_valid,
    input wire logic                retire_valid
);

    int unsigned fail_count = 0;   // failed properties so far

    reset_quiet: assert property (@(posedge clk)
        reset |-> !imem_req && !dmem_req && !retire_valid)
        else begin
            $error("request or retire active during reset");
            fail_count++;
        end

    // fetch address held until the valid pulse
    imem_hold: assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_valid |=> imem_req && $stable(imem_addr))
        else begin
            $error("fetch request dropped or address changed while waiting");
            fail_count++;
        end

    dmem_hold: assert property (@(posedge clk) disable iff (reset)
        dmem_req && !dmem_valid |=> dmem_req && $stable(dmem_cmd))
        else begin
            $error("data request dropped or command changed while waiting");
            fail_count++;
        end

    fetch_done: assert property (@(posedge clk) disable iff (reset)
        imem_req && imem_valid |=> !imem_req)
        else begin
            $error("fetch request still high after its valid");
            fail_count++;
        end

    // the instruction executes in the cycle right after its fetch
    exec_start: assert property (@(posedge clk) disable iff (reset)
        imem_req && imem_valid |=> retire_valid || dmem_req)
        else begin
            $error("no retire or data request in the cycle after the fetch");
            fail_count++;
        end

    mem_retire: assert property (@(posedge clk) disable iff (reset)
        dmem_req && dmem_valid |=> retire_valid)
        else begin
            $error("load or store did not retire in the cycle after its valid");
            fail_count++;
        end

    // one cycle pulse followed by the next fetch
    retire_pulse: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> !retire_valid && imem_req)
        else begin
            $error("retire pulse too long or no fetch after it");
            fail_count++;
        end

    one_request: assert property (@(posedge clk) disable iff (reset)
        !(imem_req && dmem_req))
        else begin
            $error("fetch and data request outstanding together");
            fail_count++;
        end

endmodule

`default_nettype wire

/* verification/rv_core_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the core with program image, random latency memories and retire checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_consts.svh"

bind rv_core rv_core_properties u_properties (.*);

module rv_core_tb;

    localparam int NUM_RETIRES = 32;
    localparam int MAX_LAT     = 5;
    // each instruction waits at most for one fetch and one data access
    localparam int CYCLE_LIMIT = NUM_RETIRES * (2 * (MAX_LAT + 1) + 2) + 8 + 20;

    logic clk;
    logic reset;
    logic imem_req;
    logic [31:0] imem_addr;
    logic imem_valid;
    logic [31:0] imem_data;
    logic dmem_req;
    rv_core_pkg::dmem_req_t dmem_cmd;
    logic dmem_valid;
    logic [31:0] dmem_rdata;
    logic retire_valid;
    rv_core_pkg::retire_t retire;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    rv_core_pkg::retire_t exp_ret [NUM_RETIRES];
    logic [31:0] exp_next [NUM_RETIRES];
    rv_core_pkg::dmem_req_t exp_store [$];

    int          num_placed;
    int          errors;
    int          retired;
    int          fetches;
    int          cycles;
    int unsigned i_wait;
    int unsigned d_wait;
    logic        i_busy;
    logic        d_busy;
    logic [31:0] exp_fetch;
    logic [31:0] i_off;
    rv_core_pkg::dmem_req_t st;

    rv_core DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // one program word plus what its retire should look like
    task automatic place(logic [31:0] off, logic [31:0] inst, logic [4:0] rd,
                         logic [31:0] wdata, logic we, logic [31:0] next_off);
        imem[off[7:2]] = inst;
        exp_ret[num_placed] = '{pc: `RV_RESET_PC + off, rd: rd, wdata: wdata, we: we};
        exp_next[num_placed] = `RV_RESET_PC + next_off;
        num_placed++;
    endtask

    task automatic report_fail(string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic build_program();
        for (int i = 0; i < 64; i++)
            imem[i] = i_type(12'(i), 0, 3'b000, 21, `RV_OP_OP_IMM);   // addi x21, x0, index
        for (int i = 0; i < 256; i++)
            dmem[i] = (32'h0000_1000 + 32'(i) * 32'd4) ^ 32'h5a5a_0000;
        place(32'h00, u_type(20'h00001, 1, `RV_OP_LUI), 1, 32'h0000_1000, 1, 32'h04);
        place(32'h04, i_type(12'hffb, 0, 3'b000, 2, `RV_OP_OP_IMM), 2, 32'hffff_fffb, 1, 32'h08);
        place(32'h08, i_type(12'h003, 0, 3'b000, 3, `RV_OP_OP_IMM), 3, 32'h3, 1, 32'h0c);
        place(32'h0c, r_type(7'h00, 3, 2, 3'b000, 4), 4, 32'hffff_fffe, 1, 32'h10);
        place(32'h10, r_type(7'h20, 2, 3, 3'b000, 5), 5, 32'h8, 1, 32'h14);
        place(32'h14, r_type(7'h00, 3, 3, 3'b001, 6), 6, 32'h18, 1, 32'h18);
        place(32'h18, r_type(7'h00, 3, 2, 3'b010, 7), 7, 32'h1, 1, 32'h1c);
        place(32'h1c, r_type(7'h00, 3, 2, 3'b011, 8), 8, 32'h0, 1, 32'h20);
        place(32'h20, r_type(7'h00, 3, 2, 3'b100, 9), 9, 32'hffff_fff8, 1, 32'h24);
        place(32'h24, r_type(7'h00, 3, 2, 3'b101, 10), 10, 32'h1fff_ffff, 1, 32'h28);
        place(32'h28, r_type(7'h20, 3, 2, 3'b101, 11), 11, 32'hffff_ffff, 1, 32'h2c);
        place(32'h2c, r_type(7'h00, 3, 2, 3'b110, 12), 12, 32'hffff_fffb, 1, 32'h30);
        place(32'h30, r_type(7'h00, 3, 2, 3'b111, 13), 13, 32'h3, 1, 32'h34);
        place(32'h34, u_type(20'h00002, 14, `RV_OP_AUIPC), 14, 32'h8000_2034, 1, 32'h38);
        // write to x0 must report we low
        place(32'h38, i_type(12'h007, 3, 3'b000, 0, `RV_OP_OP_IMM), 0, 32'h0, 0, 32'h3c);
        place(32'h3c, s_type(12'h000, 2, 1, `RV_F3_W), 0, 32'h0, 0, 32'h40);
        exp_store.push_back('{addr: 32'h1000, wdata: 32'hffff_fffb, wmask: 4'b1111, we: 1'b1});
        place(32'h40, s_type(12'h005, 3, 1, `RV_F3_B), 0, 32'h0, 0, 32'h44);
        exp_store.push_back('{addr: 32'h1004, wdata: 32'h0303_0303, wmask: 4'b0010, we: 1'b1});
        place(32'h44, i_type(12'h005, 1, `RV_F3_B, 15, `RV_OP_LOAD), 15, 32'h3, 1, 32'h48);
        place(32'h48, i_type(12'h000, 1, `RV_F3_BU, 16, `RV_OP_LOAD), 16, 32'hfb, 1, 32'h4c);
        place(32'h4c, i_type(12'h000, 1, `RV_F3_B, 17, `RV_OP_LOAD), 17, 32'hffff_fffb, 1, 32'h50);
        place(32'h50, i_type(12'h002, 1, `RV_F3_H, 18, `RV_OP_LOAD), 18, 32'hffff_ffff, 1, 32'h54);
        place(32'h54, i_type(12'h000, 1, `RV_F3_HU, 19, `RV_OP_LOAD), 19, 32'hfffb, 1, 32'h58);
        place(32'h58, i_type(12'h000, 1, `RV_F3_W, 20, `RV_OP_LOAD), 20, 32'hffff_fffb, 1, 32'h5c);
        place(32'h5c, b_type(13'd8, 5, 3, `RV_F3_BEQ), 0, 32'h0, 0, 32'h60);   // not taken
        place(32'h60, b_type(13'd8, 5, 3, `RV_F3_BNE), 0, 32'h0, 0, 32'h68);
        place(32'h68, b_type(13'd8, 3, 2, `RV_F3_BLT), 0, 32'h0, 0, 32'h70);
        place(32'h70, b_type(13'd8, 3, 2, `RV_F3_BGE), 0, 32'h0, 0, 32'h74);   // not taken
        place(32'h74, b_type(13'd8, 2, 3, `RV_F3_BLTU), 0, 32'h0, 0, 32'h7c);
        place(32'h7c, b_type(13'd8, 2, 3, `RV_F3_BGEU), 0, 32'h0, 0, 32'h80);  // not taken
        place(32'h80, j_type(21'd8, 22), 22, 32'h8000_0084, 1, 32'h88);
        // odd target has bit 0 cleared
        place(32'h88, i_type(12'd13, 22, 3'b000, 23, `RV_OP_JALR), 23, 32'h8000_008c, 1, 32'h90);
        place(32'h90, j_type(21'd0, 0), 0, 32'h0, 0, 32'h90);                  // spin here
    endtask

    task automatic check_retire();
        rv_core_pkg::retire_t e;
        e = exp_ret[retired];
        assert (retire.pc == e.pc && retire.we == e.we)
            else report_fail($sformatf("retire %0d pc %h we %b, expected pc %h we %b",
                                       retired, retire.pc, retire.we, e.pc, e.we));
        if (e.we)
            assert (retire.rd == e.rd && retire.wdata == e.wdata)
                else report_fail($sformatf("retire %0d x%0d = %h, expected x%0d = %h", retired,
                                           retire.rd, retire.wdata, e.rd, e.wdata));
        exp_fetch = exp_next[retired];
        retired++;
    endtask

    always @(negedge clk) begin
        imem_valid = 1'b0;
        dmem_valid = 1'b0;
        if (reset) begin
            assert (!imem_req && !dmem_req && !retire_valid)
                else report_fail("request or retire seen while reset is high");
        end else begin
            if (retire_valid && retired < NUM_RETIRES)
                check_retire();
            if (imem_req && !i_busy) begin        // new fetch
                assert (imem_addr == exp_fetch)
                    else report_fail($sformatf("fetch address %h, expected %h",
                                               imem_addr, exp_fetch));
                fetches++;
                i_busy = 1'b1;
                i_wait = $urandom % (MAX_LAT + 1);
            end
            if (i_busy) begin
                if (i_wait == 0) begin
                    i_off      = imem_addr - `RV_RESET_PC;
                    imem_data  = imem[i_off[7:2]];
                    imem_valid = 1'b1;
                    i_busy     = 1'b0;
                end else begin
                    i_wait--;
                end
            end
            if (dmem_req && !d_busy) begin
                d_busy = 1'b1;
                d_wait = $urandom % (MAX_LAT + 1);
            end
            if (d_busy) begin
                if (d_wait == 0) begin
                    if (dmem_cmd.we) begin
                        st = (exp_store.size() > 0) ? exp_store.pop_front() : '0;
                        assert (dmem_cmd == st)
                            else report_fail($sformatf("store cmd %h, expected %h",
                                                       dmem_cmd, st));
                        for (int b = 0; b < 4; b++)
                            if (dmem_cmd.wmask[b])
                                dmem[dmem_cmd.addr[9:2]][8*b +: 8] = dmem_cmd.wdata[8*b +: 8];
                    end else begin
                        dmem_rdata = dmem[dmem_cmd.addr[9:2]];
                    end
                    dmem_valid = 1'b1;
                    d_busy     = 1'b0;
                end else begin
                    d_wait--;
                end
            end
        end
    end

    initial begin
        void'($urandom(52476));
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_data  = '0;
        dmem_valid = 1'b0;
        dmem_rdata = '0;
        i_busy     = 1'b0;
        d_busy     = 1'b0;
        errors     = 0;
        retired    = 0;
        fetches    = 0;
        cycles     = 0;
        num_placed = 0;
        exp_fetch  = `RV_RESET_PC;
        build_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // counters move on the falling edge, so the rising edge sees them settled
        while (retired < NUM_RETIRES && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired, NUM_RETIRES);
            errors++;
        end
        assert (fetches == retired)
            else report_fail($sformatf("%0d fetches for %0d retires", fetches, retired));
        if (exp_store.size() != 0) begin
            $display("%0d expected stores never reached the data memory", exp_store.size());
            errors++;
        end
        errors += int'(DUT.u_properties.fail_count);
        $display("errors: %0d, retired: %0d, fetches: %0d, cycles: %0d",
                 errors, retired, fetches, cycles);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
